/* tb/fetch_trace.txt */
# stim: two_threads br1 tgt1 br2 tgt2 rs rat rob1 rob2 mh1 mh2 imem_valid
# then: imem_addr active_thread dec_vlo dec_vhi dec_inst_lo dec_inst_hi dec_next_pc dec_thread
# one thread streaming from 0
0 0 0   0 0  0 0 0 0 0 0 1   0    0 0 0 0    0    0    0
0 0 0   0 0  0 0 0 0 0 0 1   8    0 1 1 0    4    8    0
0 0 0   0 0  0 0 0 0 0 0 1   10   0 1 1 8    c    10   0
0 0 0   0 0  0 0 0 0 0 0 1   18   0 1 1 10   14   18   0
# two threads, thread 2 starts at 1000
1 0 0   0 0  0 0 0 0 0 0 1   20   0 1 1 18   1c   20   0
1 0 0   0 0  0 0 0 0 0 0 1   1000 1 1 1 20   24   28   0
1 0 0   0 0  0 0 0 0 0 0 1   28   0 1 1 1000 1004 1008 1
1 0 0   0 0  0 0 0 0 0 0 1   1008 1 1 1 28   2c   30   0
# thread 1 branches twice before its turn, second target into the upper half wins
1 1 204 0 0  0 0 0 0 0 0 1   30   0 1 1 1008 100c 1010 1
1 1 304 0 0  0 0 0 0 0 0 1   1010 1 1 1 30   34   38   0
1 0 0   0 0  0 0 0 0 0 0 1   38   0 1 1 1010 1014 1018 1
1 0 0   0 0  0 0 0 0 0 0 1   1018 1 0 0 0    0    40   0
1 0 0   0 0  0 0 0 0 0 0 1   300  0 1 1 1018 101c 1020 1
1 0 0   0 0  0 0 0 0 0 0 1   1020 1 0 1 0    304  308  0
1 0 0   0 0  0 0 0 0 0 0 1   308  0 1 1 1020 1024 1028 1
# global stalls then per-thread stalls on thread 2
1 0 0   0 0  1 0 0 0 0 0 1   1028 1 1 1 308  30c  310  0
1 0 0   0 0  0 1 0 0 0 0 1   310  0 0 0 0    0    1030 1
1 0 0   0 0  0 0 0 0 0 0 1   1028 1 0 0 0    0    318  0
1 0 0   0 0  0 0 0 1 0 0 1   310  0 1 1 1028 102c 1030 1
1 0 0   0 0  0 0 0 1 0 0 1   1030 1 1 1 310  314  318  0
1 0 0   0 0  0 0 0 0 0 1 1   318  0 0 0 0    0    1038 1
1 0 0   0 0  0 0 0 0 0 1 1   1030 1 1 1 318  31c  320  0
1 0 0   0 0  0 0 0 0 0 0 1   320  0 0 0 0    0    1038 1
1 0 0   0 0  0 0 0 0 0 0 1   1030 1 1 1 320  324  328  0
# memory not ready
1 0 0   0 0  0 0 0 0 0 0 0   328  0 1 1 1030 1034 1038 1
1 0 0   0 0  0 0 0 0 0 0 1   1038 1 0 0 0    0    330  0
1 0 0   0 0  0 0 0 0 0 0 1   328  0 1 1 1038 103c 1040 1
# back to one thread
0 0 0   0 0  0 0 0 0 0 0 1   330  0 1 1 328  32c  330  0
0 0 0   0 0  0 0 0 0 0 0 1   338  0 1 1 330  334  338  0
0 0 0   0 0  0 0 0 0 0 0 0   340  0 1 1 338  33c  340  0
0 0 0   0 0  0 0 0 0 0 0 1   340  0 0 0 0    0    348  0
0 0 0   0 0  0 0 0 0 0 0 1   348  0 1 1 340  344  348  0

/* fetch_stage.f */
hw/fetch_pkg.sv
hw/fetch_lane_if.sv
hw/redirect_hold.sv
hw/thread_pc.sv
hw/thread_select.sv
hw/decode_latch.sv
hw/fetch_stage.sv
tb/fetch_stage_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the fetch stage testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
	--top-module fetch_stage_tb \
	-f fetch_stage.f \
	-o fetch_stage_sim

./obj_dir/fetch_stage_sim

/* tb/fetch_stage_tb.sv */
`timescale 1ns/1ps

module fetch_stage_tb;
	import fetch_pkg::*;

	//////////////////////////////
	// dut side
	//////////////////////////////

	logic			clock;
	logic			reset;
	logic			two_threads;
	logic			branch_taken_1, branch_taken_2;
	addr_t			target_pc_1, target_pc_2;
	logic			rs_stall, rat_stall;
	logic			rob_stall_1, rob_stall_2;
	logic			mem_hazard_stall_1, mem_hazard_stall_2;
	logic [63:0]	imem_data;
	logic			imem_valid;
	addr_t			imem_addr;
	inst_t			dec_inst_lo, dec_inst_hi;
	logic			dec_valid_lo, dec_valid_hi;
	addr_t			dec_next_pc;
	thread_id_t		dec_thread, active_thread;

	// current trace line split into driven (st_) and expected (ex_) fields
	logic			st_two, st_br1, st_br2;
	addr_t			st_tgt1, st_tgt2;
	logic			st_rs, st_rat, st_rob1, st_rob2, st_mh1, st_mh2, st_ivalid;
	addr_t			ex_addr, ex_next_pc;
	logic			ex_act, ex_vlo, ex_vhi, ex_thread;
	inst_t			ex_inst_lo, ex_inst_hi;

	string			trace_lines[$];	// data lines only, comments dropped
	int				cur_line;
	logic			trace_ready;

	fetch_stage fetch_stage_inst (.*);

	// instruction memory answers in the same cycle
	// word at A holds A in the low half and A + 4 in the high half
	// upper address half folded into both
	assign imem_data = {(imem_addr[31:0] + 32'd4) ^ imem_addr[63:32],
		imem_addr[31:0] ^ imem_addr[63:32]};

	always #5 clock = ~clock;

	//////////////////////////////
	// helpers
	//////////////////////////////

	task automatic abort_run(input string why);
		$display("TEST FAILED");
		$fatal(1, "%s", why);
	endtask

	task automatic check_addr(input string name, input addr_t got, input addr_t want);
		if (got !== want)
		begin
			$display("[FAIL] %s at trace line %0d: got %h, expected %h", name, cur_line, got, want);
			abort_run("address mismatch");
		end
	endtask

	task automatic check_inst(input string name, input inst_t got, input inst_t want);
		if (got !== want)
		begin
			$display("[FAIL] %s at trace line %0d: got %h, expected %h", name, cur_line, got, want);
			abort_run("instruction mismatch");
		end
	endtask

	task automatic check_valid(input string name, input logic got, input logic want);
		if (got !== want)
		begin
			$display("[FAIL] %s at trace line %0d: got %h, expected %h", name, cur_line, got, want);
			abort_run("valid mismatch");
		end
	endtask

	task automatic check_thread(input string name, input thread_id_t got, input thread_id_t want);
		if (got !== want)
		begin
			$display("[FAIL] %s at trace line %0d: got %h, expected %h", name, cur_line, got, want);
			abort_run("thread tag mismatch");
		end
	endtask

	// splits one line into the st_ and ex_ fields, 20 on a good line
	task automatic parse_line(input string text, output int fields);
		fields = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
			st_two, st_br1, st_tgt1, st_br2, st_tgt2, st_rs, st_rat,
			st_rob1, st_rob2, st_mh1, st_mh2, st_ivalid,
			ex_addr, ex_act, ex_vlo, ex_vhi, ex_inst_lo, ex_inst_hi, ex_next_pc, ex_thread);
	endtask

	task automatic load_trace;
		int		fd;
		int		fields;
		string	text;
		fd = $fopen("tb/fetch_trace.txt", "r");
		if (fd == 0)
		begin
			abort_run("could not open the trace file tb/fetch_trace.txt");
		end
		while (!$feof(fd))
		begin
			if ($fgets(text, fd) > 0)
			begin
				parse_line(text, fields);	// comment and blank lines give no fields
				if (fields == 20)
				begin
					trace_lines.push_back(text);
				end
				else if (fields > 0)
				begin
					abort_run($sformatf("a trace line holds only %0d of 20 fields", fields));
				end
			end
		end
		$fclose(fd);
		if (trace_lines.size() == 0)
		begin
			abort_run("the trace file holds no stimulus lines");
		end
	endtask

	// called right at a rising edge
	task automatic drive_line(input string text);
		int fields;
		parse_line(text, fields);
		two_threads        <= st_two;
		branch_taken_1     <= st_br1;
		target_pc_1        <= st_tgt1;
		branch_taken_2     <= st_br2;
		target_pc_2        <= st_tgt2;
		rs_stall           <= st_rs;
		rat_stall          <= st_rat;
		rob_stall_1        <= st_rob1;
		rob_stall_2        <= st_rob2;
		mem_hazard_stall_1 <= st_mh1;
		mem_hazard_stall_2 <= st_mh2;
		imem_valid         <= st_ivalid;
	endtask

	task automatic compare_outputs;
		check_addr("imem_addr", imem_addr, ex_addr);
		check_thread("active_thread", active_thread, thread_id_t'(ex_act));
		check_valid("dec_valid_lo", dec_valid_lo, ex_vlo);
		check_valid("dec_valid_hi", dec_valid_hi, ex_vhi);
		check_inst("dec_inst_lo", dec_inst_lo, ex_inst_lo);	// zero on a bubble
		check_inst("dec_inst_hi", dec_inst_hi, ex_inst_hi);
		// tag and next pc only carry meaning next to a valid slot
		if (ex_vlo || ex_vhi)
		begin
			check_addr("dec_next_pc", dec_next_pc, ex_next_pc);
			check_thread("dec_thread", dec_thread, thread_id_t'(ex_thread));
		end
	endtask

	//////////////////////////////
	// run
	//////////////////////////////

	initial
	begin
		clock              = 1'b0;
		reset              = 1'b1;
		two_threads        = 1'b0;
		branch_taken_1     = 1'b0;
		branch_taken_2     = 1'b0;
		target_pc_1        = '0;
		target_pc_2        = '0;
		rs_stall           = 1'b0;
		rat_stall          = 1'b0;
		rob_stall_1        = 1'b0;
		rob_stall_2        = 1'b0;
		mem_hazard_stall_1 = 1'b0;
		mem_hazard_stall_2 = 1'b0;
		imem_valid         = 1'b0;
		trace_ready        = 1'b0;
		load_trace();
		trace_ready = 1'b1;
		repeat (2) @(posedge clock);	// two edges in reset
		reset <= 1'b0;
		foreach (trace_lines[i])
		begin
			cur_line = i;
			drive_line(trace_lines[i]);
			@(negedge clock);		// mid cycle, everything settled
			compare_outputs();
			@(posedge clock);
		end
		$display("TEST OK");
		$finish;
	end

	// watchdog allows one 10 ns cycle per trace line plus slack for reset
	initial
	begin
		int limit;
		wait (trace_ready === 1'b1);
		limit = (trace_lines.size() + 10) * 10;
		#(limit);
		abort_run("watchdog expired before the trace was finished");
	end

endmodule

/* hw/fetch_stage.sv */
`timescale 1ns/1ps

// fetch stage top
// two threads share one instruction port and one IF/ID register
module fetch_stage
(
	input	logic					clock,
	input	logic					reset,
	input	logic					two_threads,
	input	logic					branch_taken_1,
	input	logic					branch_taken_2,
	input	fetch_pkg::addr_t		target_pc_1,
	input	fetch_pkg::addr_t		target_pc_2,
	input	logic					rs_stall,			// reservation station full
	input	logic					rat_stall,			// free list empty
	input	logic					rob_stall_1,
	input	logic					rob_stall_2,
	input	logic					mem_hazard_stall_1,	// data side has the memory
	input	logic					mem_hazard_stall_2,
	input	logic [63:0]			imem_data,
	input	logic					imem_valid,
	output	fetch_pkg::addr_t		imem_addr,
	output	fetch_pkg::inst_t		dec_inst_lo,
	output	fetch_pkg::inst_t		dec_inst_hi,
	output	logic					dec_valid_lo,
	output	logic					dec_valid_hi,
	output	fetch_pkg::addr_t		dec_next_pc,
	output	fetch_pkg::thread_id_t	dec_thread,
	output	fetch_pkg::thread_id_t	active_thread
);
	import fetch_pkg::*;

	logic	redirect_pending_1;
	logic	redirect_pending_2;
	addr_t	redirect_pc_1;
	addr_t	redirect_pc_2;
	logic	redirect_taken_1;
	logic	redirect_taken_2;

	inst_t	sel_inst_lo;
	inst_t	sel_inst_hi;
	logic	sel_valid_lo;
	logic	sel_valid_hi;
	addr_t	sel_next_pc;

	fetch_lane_if lane1();
	fetch_lane_if lane2();

	//////////////////////////////
	// redirect capture
	//////////////////////////////

	redirect_hold hold1
	(
		.clock				(clock),
		.reset				(reset),
		.branch_taken		(branch_taken_1),
		.target_pc			(target_pc_1),
		.redirect_taken		(redirect_taken_1),
		.redirect_pending	(redirect_pending_1),
		.redirect_pc		(redirect_pc_1)
	);

	redirect_hold hold2
	(
		.clock				(clock),
		.reset				(reset),
		.branch_taken		(branch_taken_2),
		.target_pc			(target_pc_2),
		.redirect_taken		(redirect_taken_2),
		.redirect_pending	(redirect_pending_2),
		.redirect_pc		(redirect_pc_2)
	);

	//////////////////////////////
	// per-thread pcs
	//////////////////////////////

	thread_pc #(.reset_pc(THREAD1_RESET_PC)) pc1
	(
		.clock				(clock),
		.reset				(reset),
		.lane				(lane1),
		.redirect_pending	(redirect_pending_1),
		.redirect_pc		(redirect_pc_1),
		.redirect_taken		(redirect_taken_1),
		// global stalls plus this thread's own
		.stall				(rs_stall | rat_stall | rob_stall_1 | mem_hazard_stall_1),
		.imem_data			(imem_data),
		.imem_valid			(imem_valid)
	);

	thread_pc #(.reset_pc(THREAD2_RESET_PC)) pc2
	(
		.clock				(clock),
		.reset				(reset),
		.lane				(lane2),
		.redirect_pending	(redirect_pending_2),
		.redirect_pc		(redirect_pc_2),
		.redirect_taken		(redirect_taken_2),
		.stall				(rs_stall | rat_stall | rob_stall_2 | mem_hazard_stall_2),
		.imem_data			(imem_data),
		.imem_valid			(imem_valid)
	);

	//////////////////////////////
	// port owner and IF/ID
	//////////////////////////////

	thread_select select
	(
		.clock			(clock),
		.reset			(reset),
		.two_threads	(two_threads),
		.lane1			(lane1),
		.lane2			(lane2),
		.imem_addr		(imem_addr),
		.sel_inst_lo	(sel_inst_lo),
		.sel_inst_hi	(sel_inst_hi),
		.sel_valid_lo	(sel_valid_lo),
		.sel_valid_hi	(sel_valid_hi),
		.sel_next_pc	(sel_next_pc),
		.active_thread	(active_thread)
	);

	decode_latch latch
	(
		.clock			(clock),
		.reset			(reset),
		.sel_inst_lo	(sel_inst_lo),
		.sel_inst_hi	(sel_inst_hi),
		.sel_valid_lo	(sel_valid_lo),
		.sel_valid_hi	(sel_valid_hi),
		.sel_next_pc	(sel_next_pc),
		.active_thread	(active_thread),
		.dec_inst_lo	(dec_inst_lo),
		.dec_inst_hi	(dec_inst_hi),
		.dec_valid_lo	(dec_valid_lo),
		.dec_valid_hi	(dec_valid_hi),
		.dec_next_pc	(dec_next_pc),
		.dec_thread		(dec_thread)
	);

endmodule

/* hw/decode_latch.sv */
`timescale 1ns/1ps

// IF/ID register
// holds the selected pair for one cycle with the thread it came from
module decode_latch
(
	input	logic					clock,
	input	logic					reset,
	input	fetch_pkg::inst_t		sel_inst_lo,
	input	fetch_pkg::inst_t		sel_inst_hi,
	input	logic					sel_valid_lo,
	input	logic					sel_valid_hi,
	input	fetch_pkg::addr_t		sel_next_pc,
	input	fetch_pkg::thread_id_t	active_thread,
	output	fetch_pkg::inst_t		dec_inst_lo,
	output	fetch_pkg::inst_t		dec_inst_hi,
	output	logic					dec_valid_lo,
	output	logic					dec_valid_hi,
	output	fetch_pkg::addr_t		dec_next_pc,
	output	fetch_pkg::thread_id_t	dec_thread
);

	// slots and their valids
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			dec_valid_lo <= 1'b0;
			dec_valid_hi <= 1'b0;
			dec_inst_lo  <= '0;
			dec_inst_hi  <= '0;
		end
		else
		begin
			dec_valid_lo <= sel_valid_lo;
			dec_valid_hi <= sel_valid_hi;
			// bubble slots go out as zero words
			dec_inst_lo  <= sel_valid_lo ? sel_inst_lo : '0;
			dec_inst_hi  <= sel_valid_hi ? sel_inst_hi : '0;
		end
	end

	// tag and next pc ride along with the pair
	always_ff @(posedge clock)
	begin
		dec_next_pc <= sel_next_pc;
		dec_thread  <= active_thread;
	end

endmodule

/* hw/thread_select.sv */
`timescale 1ns/1ps

// round-robin owner of the memory port
// one lane is enabled per cycle and its address and pair are passed on
module thread_select
(
	input	logic					clock,
	input	logic					reset,
	input	logic					two_threads,	// low means thread 1 runs alone
	fetch_lane_if.lane_sel			lane1,
	fetch_lane_if.lane_sel			lane2,
	output	fetch_pkg::addr_t		imem_addr,
	output	fetch_pkg::inst_t		sel_inst_lo,
	output	fetch_pkg::inst_t		sel_inst_hi,
	output	logic					sel_valid_lo,
	output	logic					sel_valid_hi,
	output	fetch_pkg::addr_t		sel_next_pc,
	output	fetch_pkg::thread_id_t	active_thread
);
	import fetch_pkg::*;

	thread_id_t	thread_state;	// turn taken in two-thread mode

	////////////////////////////////
	// turn keeping
	////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			thread_state <= thread_1;
		end
		else if (!two_threads)
		begin
			thread_state <= thread_1;	// park on thread 1 when running alone
		end
		else
		begin
			// flips every cycle, stalls do not matter here
			thread_state <= (thread_state == thread_1) ? thread_2 : thread_1;
		end
	end

	assign active_thread = two_threads ? thread_state : thread_1;

	// exactly one lane live
	assign lane1.enable = (active_thread == thread_1);
	assign lane2.enable = (active_thread == thread_2);

	////////////////////////////////
	// lane mux
	////////////////////////////////

	always_comb
	begin
		if (active_thread == thread_1)
		begin
			imem_addr    = lane1.fetch_addr;
			sel_inst_lo  = lane1.inst_lo;
			sel_inst_hi  = lane1.inst_hi;
			sel_valid_lo = lane1.valid_lo;
			sel_valid_hi = lane1.valid_hi;
			sel_next_pc  = lane1.next_pc;
		end
		else
		begin
			imem_addr    = lane2.fetch_addr;
			sel_inst_lo  = lane2.inst_lo;
			sel_inst_hi  = lane2.inst_hi;
			sel_valid_lo = lane2.valid_lo;
			sel_valid_hi = lane2.valid_hi;
			sel_next_pc  = lane2.next_pc;
		end
	end

endmodule

/* hw/thread_pc.sv */
`timescale 1ns/1ps

// program counter of one thread
// builds the aligned fetch address, splits the returned word into two
// instructions and decides whether either of them is good
module thread_pc
#(
	parameter fetch_pkg::addr_t reset_pc = fetch_pkg::THREAD1_RESET_PC
)
(
	input	logic				clock,
	input	logic				reset,
	fetch_lane_if.lane_src		lane,
	input	logic				redirect_pending,	// hold has a target waiting
	input	fetch_pkg::addr_t	redirect_pc,
	output	logic				redirect_taken,		// tells the hold to clear
	input	logic				stall,				// any global or per-thread stall
	input	logic [63:0]		imem_data,			// two instructions per word
	input	logic				imem_valid
);
	import fetch_pkg::*;

	addr_t	pc;			// may sit on the upper half after a redirect
	addr_t	aligned_pc;
	logic	fetch_ok;	// memory answered and nothing holds this thread

	////////////////////////////////
	// address and data split
	////////////////////////////////

	// drop the offset inside the pair
	assign aligned_pc = pc & ~(FETCH_BYTES - 64'd1);
	assign lane.fetch_addr = aligned_pc;
	assign lane.next_pc = aligned_pc + FETCH_BYTES;

	assign lane.inst_lo = imem_data[31:0];	// instruction at aligned_pc
	assign lane.inst_hi = imem_data[63:32];	// instruction at aligned_pc + 4

	////////////////////////////////
	// control
	////////////////////////////////

	assign fetch_ok = imem_valid & ~stall;

	// a redirect goes in on our turn no matter what stalls say
	assign redirect_taken = lane.enable & redirect_pending;

	// the pair is thrown away on the redirect cycle
	assign lane.valid_hi = fetch_ok & ~redirect_taken;
	// lower slot is skipped when the pc points into the middle of the pair
	assign lane.valid_lo = fetch_ok & ~redirect_taken & ~pc[2];

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			pc <= reset_pc;
		end
		else if (lane.enable)
		begin
			if (redirect_pending)
			begin
				pc <= redirect_pc;		// branch target first
			end
			else if (fetch_ok)
			begin
				pc <= lane.next_pc;		// step past the pair just fetched
			end
			// otherwise hold so nothing gets skipped
		end
	end

endmodule

/* hw/redirect_hold.sv */
`timescale 1ns/1ps

// keeps one taken-branch target around until the thread's pc picks it up
// the thread may not own the port when the branch resolves
module redirect_hold
(
	input	logic				clock,
	input	logic				reset,
	input	logic				branch_taken,		// pulse from the execute side
	input	fetch_pkg::addr_t	target_pc,			// resolved branch target
	input	logic				redirect_taken,		// pc loaded the target this edge
	output	logic				redirect_pending,
	output	fetch_pkg::addr_t	redirect_pc
);

	////////////////////////////////
	// pending flag
	////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			redirect_pending <= 1'b0;
		end
		else if (branch_taken)
		begin
			// a fresh branch wins over a consume on the same edge
			redirect_pending <= 1'b1;
		end
		else if (redirect_taken)
		begin
			redirect_pending <= 1'b0;	// target handed over
		end
	end

	////////////////////////////////
	// target register
	////////////////////////////////

	// target of the latest taken branch
	always_ff @(posedge clock)
	begin
		if (branch_taken)
		begin
			// younger branch resolved later so its target replaces the old one
			redirect_pc <= target_pc;
		end
	end

endmodule

/* hw/fetch_lane_if.sv */
`timescale 1ns/1ps

// one thread's fetch lane
// the pc side fills it every cycle, the selector decides which lane is live
interface fetch_lane_if;
	import fetch_pkg::*;

	logic	enable;		// lane owns the memory port this cycle
	addr_t	fetch_addr;	// pair-aligned address for memory
	addr_t	next_pc;	// address right after the pair
	inst_t	inst_lo;	// instruction at fetch_addr
	inst_t	inst_hi;	// instruction at fetch_addr + 4
	logic	valid_lo;
	logic	valid_hi;

	// pc side
	modport lane_src
	(
		input	enable,
		output	fetch_addr, next_pc,
		output	inst_lo, inst_hi,
		output	valid_lo, valid_hi
	);

	// selector side
	modport lane_sel
	(
		output	enable,
		input	fetch_addr, next_pc,
		input	inst_lo, inst_hi,
		input	valid_lo, valid_hi
	);

endinterface

/* hw/fetch_pkg.sv */
package fetch_pkg;

	////////////////////////////////
	// basic fetch types
	////////////////////////////////

	// byte address as seen by the core and the instruction memory
	typedef logic [63:0] addr_t;

	// one instruction, half of a memory word
	typedef logic [31:0] inst_t;

	// owner of the memory port in the current cycle
	typedef enum logic
	{
		thread_1 = 1'b0,	// also the only thread in one-thread mode
		thread_2 = 1'b1
	} thread_id_t;

	////////////////////////////////
	// fetch geometry and start points
	////////////////////////////////

	// one access brings back a pair of instructions
	localparam addr_t FETCH_BYTES = 64'd8;

	// where each thread begins after reset
	localparam addr_t THREAD1_RESET_PC = 64'h0;
	localparam addr_t THREAD2_RESET_PC = 64'h1000;	// keeps the two streams apart in memory

endpackage
